//--- design/ahb_lite_pkg.sv
`default_nettype none

package ahb_lite_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    typedef enum logic [1:0] {
        SLV_RESET_RAM = 2'd0,
        SLV_RAM       = 2'd1,
        SLV_GPIO      = 2'd2,
        SLV_NONE      = 2'd3
    } slave_id_t;

    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hsize_t      hsize;
        logic [2:0]  hburst;
        logic [3:0]  hprot;
        logic        hmastlock;
        logic        hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_rsp_t;

    // Physical address bits 28:22
    localparam logic [6:0] RESET_RAM_MATCH = 7'h7f;
    localparam logic [6:0] GPIO_MATCH      = 7'h7e;
    localparam logic       RAM_MATCH       = 1'b0;

    localparam int RESET_RAM_WORDS_LOG2 = 15;
    localparam int RAM_WORDS_LOG2       = 16;

    localparam logic [4:0] GPIO_RED_LEDS     = 5'h00;
    localparam logic [4:0] GPIO_GREEN_LEDS   = 5'h04;
    localparam logic [4:0] GPIO_SWITCHES     = 5'h08;
    localparam logic [4:0] GPIO_BUTTONS      = 5'h0c;
    localparam logic [4:0] GPIO_LIGHT_SENSOR = 5'h10;

    function automatic logic trans_active(htrans_t t);
        return (t == NONSEQ) || (t == SEQ);
    endfunction

    // Big endian mirrors the byte lanes within the word
    function automatic logic [3:0] lane_mask(hsize_t size, logic [1:0] addr,
                                             logic big_endian);
        logic [1:0] lane;
        lane = addr ^ {2{big_endian}};
        case (size)
            BYTE:    return 4'b0001 << lane;
            HALF:    return lane[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/ahb_lite_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_lite_interconnect import ahb_lite_pkg::*; (
    input  logic        HCLK,
    input  logic        reset,
    input  ahb_req_t    req,
    input  ahb_rsp_t    rsp_reset_ram,
    input  ahb_rsp_t    rsp_ram,
    input  ahb_rsp_t    rsp_gpio,
    output logic        hsel_reset_ram,
    output logic        hsel_ram,
    output logic        hsel_gpio,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp
);

    typedef enum logic [1:0] {
        ERR_IDLE,
        ERR_FIRST,
        ERR_SECOND
    } err_state_t;

    slave_id_t  addr_sel;
    slave_id_t  data_sel;
    err_state_t err_state;
    logic       err_start;

    // Reset RAM and GPIO share bit 28 with each other, so they win over main RAM
    always_comb begin
        if (req.haddr[28:22] == RESET_RAM_MATCH) begin
            addr_sel = SLV_RESET_RAM;
        end else if (req.haddr[28:22] == GPIO_MATCH) begin
            addr_sel = SLV_GPIO;
        end else if (req.haddr[28] == RAM_MATCH) begin
            addr_sel = SLV_RAM;
        end else begin
            addr_sel = SLV_NONE;
        end
    end

    assign hsel_reset_ram = (req.haddr[28:22] == RESET_RAM_MATCH);
    assign hsel_ram       = (req.haddr[28] == RAM_MATCH);
    assign hsel_gpio      = (req.haddr[28:22] == GPIO_MATCH);

    assign err_start = hready && (addr_sel == SLV_NONE) && trans_active(req.htrans);

    always_ff @(posedge HCLK) begin
        if (reset) begin
            data_sel <= SLV_RAM;
        end else if (hready) begin
            data_sel <= addr_sel;
        end
    end

    // Default slave for unmapped transfers
    always_ff @(posedge HCLK) begin
        if (reset) begin
            err_state <= ERR_IDLE;
        end else begin
            case (err_state)
                ERR_IDLE: begin
                    if (err_start) begin
                        err_state <= ERR_FIRST;
                    end
                end
                ERR_FIRST: begin
                    err_state <= ERR_SECOND;
                end
                default: begin
                    err_state <= err_start ? ERR_FIRST : ERR_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (data_sel)
            SLV_RESET_RAM: begin
                hrdata = rsp_reset_ram.hrdata;
                hready = rsp_reset_ram.hready;
                hresp  = rsp_reset_ram.hresp;
            end
            SLV_RAM: begin
                hrdata = rsp_ram.hrdata;
                hready = rsp_ram.hready;
                hresp  = rsp_ram.hresp;
            end
            SLV_GPIO: begin
                hrdata = rsp_gpio.hrdata;
                hready = rsp_gpio.hready;
                hresp  = rsp_gpio.hresp;
            end
            default: begin
                hrdata = '0;
                hready = (err_state != ERR_FIRST);
                hresp  = (err_state != ERR_IDLE);
            end
        endcase
    end

    // Address map regions never overlap
    assert property (@(posedge HCLK) disable iff (reset)
        $onehot0({hsel_reset_ram, hsel_ram, hsel_gpio}));

    // ERROR always takes the stalled cycle before the final one
    assert property (@(posedge HCLK) disable iff (reset)
        (hresp && hready) |-> $past(hresp && !hready));

endmodule

`default_nettype wire

//--- design/ahb_ram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_ram_slave import ahb_lite_pkg::*; #(
    parameter int words_log2 = RAM_WORDS_LOG2
) (
    input  logic        HCLK,
    input  logic        reset,
    input  logic        hsel,
    input  ahb_req_t    req,
    input  logic        hready_in,
    input  logic [31:0] hwdata,
    input  logic        si_endian,
    output ahb_rsp_t    rsp
);

    logic [31:0]           mem [0:(1 << words_log2) - 1];
    logic [words_log2-1:0] addr_q;
    logic [3:0]            mask_q;
    logic                  write_q;
    logic                  accept;
    logic [31:0]           rd_word;

    assign accept = hsel && hready_in && trans_active(req.htrans);

    // Address phase capture
    always_ff @(posedge HCLK) begin
        if (accept) begin
            addr_q <= req.haddr[words_log2+1:2];
            mask_q <= lane_mask(req.hsize, req.haddr[1:0], si_endian);
        end
    end

    always_ff @(posedge HCLK) begin
        if (reset) begin
            write_q <= 1'b0;
        end else if (hready_in) begin
            write_q <= accept && req.hwrite;
        end
    end

    // Data phase write of the enabled lanes
    always_ff @(posedge HCLK) begin
        if (write_q && hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (mask_q[i]) begin
                    mem[addr_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // lanes being written this cycle bypass the array
    always_comb begin
        rd_word = mem[addr_q];
        for (int i = 0; i < 4; i++) begin
            if (write_q && mask_q[i]) begin
                rd_word[8*i +: 8] = hwdata[8*i +: 8];
            end
        end
    end

    assign rsp = '{hrdata: rd_word, hready: 1'b1, hresp: 1'b0};

    assert property (@(posedge HCLK) disable iff (reset)
        (hready_in && hsel && req.hwrite && !trans_active(req.htrans)) |=> !write_q);

endmodule

`default_nettype wire

//--- design/ahb_gpio_slave.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio_slave import ahb_lite_pkg::*; (
    input  logic        HCLK,
    input  logic        reset,
    input  logic        hsel,
    input  ahb_req_t    req,
    input  logic        hready_in,
    input  logic [31:0] hwdata,
    input  logic        si_endian,
    input  logic [17:0] switches,
    input  logic [4:0]  buttons,
    input  logic [15:0] light_sensor,
    output logic [17:0] red_leds,
    output logic [8:0]  green_leds,
    output ahb_rsp_t    rsp
);

    typedef enum logic {
        GPIO_READY,
        GPIO_WAIT
    } gpio_state_t;

    gpio_state_t state;
    logic        accept;
    logic        write_q;
    logic [4:0]  offset_q;
    logic [3:0]  mask_q;
    logic [31:0] bit_mask;
    logic [31:0] rd_value;
    logic [31:0] hrdata_q;
    logic [17:0] switches_meta;
    logic [17:0] switches_sync;
    logic [4:0]  buttons_meta;
    logic [4:0]  buttons_sync;
    logic [15:0] light_meta;
    logic [15:0] light_sync;

    assign accept = hsel && hready_in && trans_active(req.htrans);

    always_ff @(posedge HCLK) begin
        if (accept) begin
            offset_q <= req.haddr[4:0];
            mask_q   <= lane_mask(req.hsize, req.haddr[1:0], si_endian);
        end
    end

    // Reads insert a single wait state
    always_ff @(posedge HCLK) begin
        if (reset) begin
            state   <= GPIO_READY;
            write_q <= 1'b0;
        end else begin
            if (hready_in) begin
                write_q <= accept && req.hwrite;
            end
            case (state)
                GPIO_READY: begin
                    if (accept && !req.hwrite) begin
                        state <= GPIO_WAIT;
                    end
                end
                default: begin
                    state <= GPIO_READY;
                end
            endcase
        end
    end

    assign bit_mask = {{8{mask_q[3]}}, {8{mask_q[2]}}, {8{mask_q[1]}}, {8{mask_q[0]}}};

    always_ff @(posedge HCLK) begin
        if (reset) begin
            red_leds   <= '0;
            green_leds <= '0;
        end else if (write_q && hready_in) begin
            if (offset_q == GPIO_RED_LEDS) begin
                red_leds <= (red_leds & ~bit_mask[17:0]) | (hwdata[17:0] & bit_mask[17:0]);
            end
            if (offset_q == GPIO_GREEN_LEDS) begin
                green_leds <= (green_leds & ~bit_mask[8:0]) | (hwdata[8:0] & bit_mask[8:0]);
            end
        end
    end

    // Two-flop synchronizers for the board inputs
    always_ff @(posedge HCLK) begin
        switches_meta <= switches;
        switches_sync <= switches_meta;
        buttons_meta  <= buttons;
        buttons_sync  <= buttons_meta;
        light_meta    <= light_sensor;
        light_sync    <= light_meta;
    end

    always_comb begin
        case (offset_q)
            GPIO_RED_LEDS:     rd_value = {14'b0, red_leds};
            GPIO_GREEN_LEDS:   rd_value = {23'b0, green_leds};
            GPIO_SWITCHES:     rd_value = {14'b0, switches_sync};
            GPIO_BUTTONS:      rd_value = {27'b0, buttons_sync};
            GPIO_LIGHT_SENSOR: rd_value = {16'b0, light_sync};
            default:           rd_value = '0;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (state == GPIO_WAIT) begin
            hrdata_q <= rd_value;
        end
    end

    assign rsp = '{hrdata: hrdata_q, hready: (state != GPIO_WAIT), hresp: 1'b0};

    assert property (@(posedge HCLK) disable iff (reset)
        (accept && !req.hwrite) |=> !rsp.hready ##1 rsp.hready);

endmodule

`default_nettype wire

//--- design/ahb_lite_soc.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_lite_soc import ahb_lite_pkg::*; (
    input  logic        HCLK,
    input  logic        reset,
    input  ahb_req_t    req,
    input  logic [31:0] hwdata,
    input  logic        si_endian,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    input  logic [17:0] switches,
    input  logic [4:0]  buttons,
    input  logic [15:0] light_sensor,
    output logic [17:0] red_leds,
    output logic [8:0]  green_leds
);

    logic     hsel_reset_ram;
    logic     hsel_ram;
    logic     hsel_gpio;
    ahb_rsp_t rsp_reset_ram;
    ahb_rsp_t rsp_ram;
    ahb_rsp_t rsp_gpio;

    ahb_lite_interconnect bus_ic (
        .HCLK           (HCLK),
        .reset          (reset),
        .req            (req),
        .rsp_reset_ram  (rsp_reset_ram),
        .rsp_ram        (rsp_ram),
        .rsp_gpio       (rsp_gpio),
        .hsel_reset_ram (hsel_reset_ram),
        .hsel_ram       (hsel_ram),
        .hsel_gpio      (hsel_gpio),
        .hrdata         (hrdata),
        .hready         (hready),
        .hresp          (hresp)
    );

    // 128 KB boot memory at physical 0x1fc00000
    ahb_ram_slave #(
        .words_log2 (RESET_RAM_WORDS_LOG2)
    ) reset_ram (
        .HCLK      (HCLK),
        .reset     (reset),
        .hsel      (hsel_reset_ram),
        .req       (req),
        .hready_in (hready),
        .hwdata    (hwdata),
        .si_endian (si_endian),
        .rsp       (rsp_reset_ram)
    );

    ahb_ram_slave #(
        .words_log2 (RAM_WORDS_LOG2)
    ) ram (
        .HCLK      (HCLK),
        .reset     (reset),
        .hsel      (hsel_ram),
        .req       (req),
        .hready_in (hready),
        .hwdata    (hwdata),
        .si_endian (si_endian),
        .rsp       (rsp_ram)
    );

    ahb_gpio_slave gpio (
        .HCLK         (HCLK),
        .reset        (reset),
        .hsel         (hsel_gpio),
        .req          (req),
        .hready_in    (hready),
        .hwdata       (hwdata),
        .si_endian    (si_endian),
        .switches     (switches),
        .buttons      (buttons),
        .light_sensor (light_sensor),
        .red_leds     (red_leds),
        .green_leds   (green_leds),
        .rsp          (rsp_gpio)
    );

endmodule

`default_nettype wire

//--- test/ahb_lite_soc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_lite_soc_tb import ahb_lite_pkg::*; ();

    localparam int          RESET_CYCLES   = 8;
    localparam int          RAND_WORDS     = 8;
    // Each transfer takes at most three cycles
    localparam int          TRANSFERS      = 4 * RAND_WORDS + 26 + 8 + 11 + 4;
    localparam int          TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 3 * TRANSFERS);
    localparam logic [31:0] RESET_RAM_BASE = {3'b000, RESET_RAM_MATCH, 22'h0};
    localparam logic [31:0] UNMAPPED_ADDR  = 32'h1000_0000;

    logic        HCLK;
    logic        reset;
    ahb_req_t    req;
    logic [31:0] hwdata;
    logic        si_endian;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic [17:0] switches;
    logic [4:0]  buttons;
    logic [15:0] light_sensor;
    logic [17:0] red_leds;
    logic [8:0]  green_leds;

    logic [31:0] lfsr;
    logic [31:0] mem_model [logic [31:0]];
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int          prop_errors = 0;
    int          cycles = 0;
    string       test_name;

    ahb_lite_soc dut0 (.*);

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = 32'h0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic ahb_req_t make_req(input logic [31:0] addr, input hsize_t size,
                                          input logic is_write, input htrans_t trans);
        ahb_req_t r;
        r.haddr     = addr;
        r.htrans    = trans;
        r.hsize     = size;
        r.hburst    = 3'b000;
        r.hprot     = 4'b0011;
        r.hmastlock = 1'b0;
        r.hwrite    = is_write;
        return r;
    endfunction

    function automatic logic [31:0] gpio_addr(input logic [4:0] offset);
        return {3'b000, GPIO_MATCH, 17'h0, offset};
    endfunction

    function automatic logic is_gpio(input logic [31:0] addr);
        return addr[28:22] == GPIO_MATCH;
    endfunction

    function automatic logic is_unmapped(input logic [31:0] addr);
        return addr[28:22] != RESET_RAM_MATCH && !is_gpio(addr) && addr[28] != RAM_MATCH;
    endfunction

    // Big endian counts byte lanes from the top of the word
    function automatic logic [3:0] lanes_for(input hsize_t size, input logic [1:0] offset,
                                             input logic big);
        logic [3:0] mask;
        case (size)
            BYTE:    mask = big ? 4'b1000 >> offset : 4'b0001 << offset;
            HALF:    mask = (offset[1] ^ big) ? 4'b1100 : 4'b0011;
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    task automatic model_write(input logic [31:0] addr, input hsize_t size,
                               input logic [31:0] wdata, input logic big);
        logic [31:0] key;
        logic [31:0] word;
        logic [3:0]  lanes;
        key   = {addr[31:2], 2'b00};
        word  = mem_model.exists(key) ? mem_model[key] : 32'h0;
        lanes = lanes_for(size, addr[1:0], big);
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                word[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        mem_model[key] = word;
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors + prop_errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors + prop_errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors + prop_errors - test_errors);
        end
    endtask

    // One address phase, then the data phase until hready
    task automatic bus_transfer(input logic is_write, input logic [31:0] addr, input hsize_t size,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output int waits, output logic err);
        waits = 0;
        @(posedge HCLK);
        req <= make_req(addr, size, is_write, NONSEQ);
        @(posedge HCLK);
        req    <= make_req(32'h0, WORD, 1'b0, IDLE);
        hwdata <= is_write ? wdata : 32'h0;
        @(negedge HCLK);
        while (!hready) begin
            waits++;
            @(negedge HCLK);
        end
        rdata = hrdata;
        err   = hresp;
    endtask

    // Read address phase overlaps the write data phase
    task automatic write_then_read(input logic [31:0] addr, input logic [31:0] wdata,
                                   output logic [31:0] rdata);
        @(posedge HCLK);
        req <= make_req(addr, WORD, 1'b1, NONSEQ);
        @(posedge HCLK);
        req    <= make_req(addr, WORD, 1'b0, NONSEQ);
        hwdata <= wdata;
        @(posedge HCLK);
        req    <= make_req(32'h0, WORD, 1'b0, IDLE);
        hwdata <= 32'h0;
        @(negedge HCLK);
        rdata = hrdata;
    endtask

    task automatic gpio_read(input logic [4:0] offset, input logic [31:0] expected,
                             input string what);
        logic [31:0] rdata;
        int          waits;
        logic        err;
        bus_transfer(1'b0, gpio_addr(offset), WORD, 32'h0, rdata, waits, err);
        check_value(what, expected, rdata);
        check_value("gpio read wait states", 32'h1, 32'(waits));
    endtask

    task automatic ram_words();
        logic [31:0] addrs [$];
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        int          waits;
        logic        err;
        begin_test("ram_words");
        @(negedge HCLK);
        check_value("hready after reset", 32'h1, 32'(hready));
        check_value("hresp after reset", 32'h0, 32'(hresp));
        check_value("leds after reset", 32'h0, {5'b0, green_leds, red_leds});
        for (int i = 0; i < 2 * RAND_WORDS; i++) begin
            take_bits(i < RAND_WORDS ? RESET_RAM_WORDS_LOG2 : RAM_WORDS_LOG2, addr);
            addr = (i < RAND_WORDS ? RESET_RAM_BASE : 32'h0) + (addr << 2);
            take_bits(32, data);
            bus_transfer(1'b1, addr, WORD, data, rdata, waits, err);
            model_write(addr, WORD, data, 1'b0);
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            bus_transfer(1'b0, addrs[i], WORD, 32'h0, rdata, waits, err);
            check_value("read data", mem_model[addrs[i]], rdata);
            check_value("read response", 32'h0, 32'(err));
        end
        end_test();
    endtask

    task automatic ram_byte_lanes();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        hsize_t      size;
        int          waits;
        logic        err;
        begin_test("ram_byte_lanes");
        for (int e = 0; e < 2; e++) begin
            @(posedge HCLK);
            si_endian <= e[0];
            take_bits(32, data);
            bus_transfer(1'b1, 32'h200, WORD, data, rdata, waits, err);
            model_write(32'h200, WORD, data, e[0]);
            // Four byte writes, then both halfwords
            for (int k = 0; k < 6; k++) begin
                if (k < 4) begin
                    size = BYTE;
                    addr = 32'h200 + 32'(k);
                end else begin
                    size = HALF;
                    addr = 32'h200 + 32'(2 * (k - 4));
                end
                take_bits(32, data);
                bus_transfer(1'b1, addr, size, data, rdata, waits, err);
                model_write(addr, size, data, e[0]);
                bus_transfer(1'b0, 32'h200, WORD, 32'h0, rdata, waits, err);
                check_value(e[0] ? "big endian lanes" : "little endian lanes",
                            mem_model[32'h200], rdata);
            end
        end
        @(posedge HCLK);
        si_endian <= 1'b0;
        end_test();
    endtask

    task automatic write_read_forwarding();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        begin_test("write_read_forwarding");
        for (int k = 0; k < 4; k++) begin
            take_bits(RAM_WORDS_LOG2, addr);
            take_bits(32, data);
            addr = addr << 2;
            write_then_read(addr, data, rdata);
            model_write(addr, WORD, data, 1'b0);
            check_value("read after write", mem_model[addr], rdata);
        end
        end_test();
    endtask

    task automatic gpio_registers();
        logic [31:0] red;
        logic [31:0] green;
        logic [31:0] sw;
        logic [31:0] bt;
        logic [31:0] ls;
        logic [31:0] rdata;
        int          waits;
        logic        err;
        begin_test("gpio_registers");
        take_bits(18, red);
        take_bits(9, green);
        take_bits(18, sw);
        take_bits(5, bt);
        take_bits(16, ls);
        bus_transfer(1'b1, gpio_addr(GPIO_RED_LEDS), WORD, red, rdata, waits, err);
        bus_transfer(1'b1, gpio_addr(GPIO_GREEN_LEDS), WORD, green, rdata, waits, err);
        gpio_read(GPIO_RED_LEDS, red, "red_leds readback");
        check_value("red_leds output", red, 32'(red_leds));
        gpio_read(GPIO_GREEN_LEDS, green, "green_leds readback");
        check_value("green_leds output", green, 32'(green_leds));
        @(posedge HCLK);
        switches     <= sw[17:0];
        buttons      <= bt[4:0];
        light_sensor <= ls[15:0];
        repeat (3) @(posedge HCLK);
        gpio_read(GPIO_SWITCHES, sw, "switches");
        gpio_read(GPIO_BUTTONS, bt, "buttons");
        gpio_read(GPIO_LIGHT_SENSOR, ls, "light_sensor");
        end_test();
    endtask

    task automatic unmapped_access();
        logic [31:0] data;
        logic [31:0] rdata;
        int          waits;
        logic        err;
        begin_test("unmapped_access");
        for (int k = 0; k < 2; k++) begin
            bus_transfer(k == 1, UNMAPPED_ADDR + 32'(4 * k), WORD, 32'h0, rdata, waits, err);
            check_value("error response", 32'h1, 32'(err));
            check_value("error wait states", 32'h1, 32'(waits));
        end
        take_bits(32, data);
        bus_transfer(1'b1, 32'h40, WORD, data, rdata, waits, err);
        model_write(32'h40, WORD, data, 1'b0);
        bus_transfer(1'b0, 32'h40, WORD, 32'h0, rdata, waits, err);
        check_value("ram read after error", mem_model[32'h40], rdata);
        check_value("ram response after error", 32'h0, 32'(err));
        end_test();
    endtask

    assert property (@(posedge HCLK) disable iff (reset)
        (hready && req.htrans == NONSEQ && !is_gpio(req.haddr) && !is_unmapped(req.haddr))
        |=> (hready && !hresp))
        else begin
            prop_errors++;
            $display("assertion failed: RAM data phase was not zero-wait OKAY");
        end

    assert property (@(posedge HCLK) disable iff (reset)
        (hready && req.htrans == NONSEQ && is_gpio(req.haddr) && !req.hwrite)
        |=> !hready ##1 hready)
        else begin
            prop_errors++;
            $display("assertion failed: GPIO read did not stall for exactly one cycle");
        end

    assert property (@(posedge HCLK) disable iff (reset)
        (hready && req.htrans == NONSEQ && is_unmapped(req.haddr))
        |=> (!hready && hresp) ##1 (hready && hresp))
        else begin
            prop_errors++;
            $display("assertion failed: unmapped access did not get the two-cycle ERROR");
        end

    initial begin
        reset        = 1'b1;
        req          = make_req(32'h0, WORD, 1'b0, IDLE);
        hwdata       = 32'h0;
        si_endian    = 1'b0;
        switches     = '0;
        buttons      = '0;
        light_sensor = '0;
        lfsr         = 32'h3625_73e6;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        repeat (RESET_CYCLES) @(posedge HCLK);
        reset <= 1'b0;
        ram_words();
        ram_byte_lanes();
        write_read_forwarding();
        gpio_registers();
        unmapped_access();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ahb_lite_soc.f
design/ahb_lite_pkg.sv
design/ahb_lite_interconnect.sv
design/ahb_ram_slave.sv
design/ahb_gpio_slave.sv
design/ahb_lite_soc.sv
test/ahb_lite_soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module ahb_lite_soc_tb -f ahb_lite_soc.f \
    -o ahb_lite_soc_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/ahb_lite_soc_sim)
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
